// File: fcb_apb_slave.sv
// APB slave front end of the FCB
// Turns each access into a write FIFO entry and answers reads from the read FIFO
`include "fcb_consts.svh"

module fcb_apb_slave
  import fcb_pkg::*;
(
  input  logic         fcb_sys_clk,
  input  logic         fcb_sys_rst_n,
  input  logic         spi_mode_en,  // High when the SPI path owns the FCB
  input  logic [19:0]  paddr,        // Byte address
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  logic [31:0]  pwdata,
  output logic         pready,
  output logic [31:0]  prdata,
  output logic         pslverr,
  output logic         apb_on,       // APB path active
  fcb_fifo_if.producer wff,          // Write FIFO push side
  fcb_fifo_if.consumer crf           // Config read FIFO pop side
);

  aps_state_e state_q;
  aps_state_e state_d;
  logic       pready_q;
  logic       pready_d;

  logic       sfr_space;   // Upper address bits all zero
  logic       cfg_port;    // Access targets the config data port
  logic       push_acc;    // Write data phase with PREADY
  logic       sfr_rd_req;  // Read request push in setup
  wff_kind_e  acc_kind;
  wff_entry_t entry;

  assign pready  = pready_q;
  assign prdata  = crf.rd_data; // Head of read FIFO
  assign pslverr = 1'b0;        // No error responses
  assign apb_on  = ~spi_mode_en;

  // Address decode
  assign sfr_space = (paddr[19:9] == '0);
  assign cfg_port  = !sfr_space || (paddr[8:2] == `FCB_CFGDP_ADDR);

  // FIFO strobes
  assign push_acc  = pready_q && penable && psel && pwrite;
  assign wff.wr_en = push_acc || sfr_rd_req;
  assign crf.rd_en = pready_q && penable && psel && !pwrite; // Pop on completion

  // Entry kind for the current push
  always_comb begin
    if (sfr_rd_req) begin
      acc_kind = WFF_SFR_RD;
    end else if (cfg_port) begin
      acc_kind = WFF_CFG_WR;
    end else begin
      acc_kind = WFF_SFR_WR;
    end
  end

  // Build the entry
  always_comb begin
    entry.wr   = (acc_kind != WFF_SFR_RD);
    entry.addr = (acc_kind == WFF_CFG_WR) ? `FCB_CFGDP_ADDR : paddr[8:2]; // Port alias
    entry.data = (acc_kind == WFF_SFR_RD) ? '0 : pwdata;
  end

  assign wff.wr_data = entry;

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      state_q  <= APS_START;
      pready_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      pready_q <= pready_d;
    end
  end

  // Access FSM
  always_comb begin
    state_d    = state_q;
    pready_d   = pready_q;
    sfr_rd_req = 1'b0;

    case (state_q)
      APS_START: begin
        state_d = APS_IDLE;
      end

      APS_IDLE: begin
        if (psel && pwrite) begin
          // Any write needs one free entry
          if (!wff.full) begin
            pready_d = 1'b1;
            state_d  = APS_WR_DONE;
          end
        end else if (psel && cfg_port) begin
          if (!crf.empty) begin // Config read waits for data
            pready_d = 1'b1;
            state_d  = APS_RD_DONE;
          end
        end else if (psel) begin
          // SFR read goes through the engine
          if (!wff.full) begin
            sfr_rd_req = 1'b1;
            state_d    = APS_SFR_WAIT;
          end
        end
      end

      APS_WR_DONE: begin
        pready_d = 1'b0; // Entry pushed this cycle
        state_d  = APS_IDLE;
      end

      APS_RD_DONE: begin
        pready_d = 1'b0; // Word popped this cycle
        state_d  = APS_IDLE;
      end

      APS_SFR_WAIT: begin
        if (!crf.empty) begin
          pready_d = 1'b1;
          state_d  = APS_RD_DONE;
        end
      end

      default: begin
        state_d = APS_IDLE;
      end
    endcase
  end

endmodule

// File: fcb_apb_top.sv
// Top level of the FCB APB configuration path
// Connects the APB slave and the config engine through the write and read FIFOs
`include "fcb_consts.svh"

module fcb_apb_top
  import fcb_pkg::*;
(
  input  logic        fcb_sys_clk,
  input  logic        fcb_sys_rst_n,
  input  logic        fcb_spi_mode_en,
  input  logic [19:0] fcb_apbs_paddr,
  input  logic        fcb_apbs_psel,
  input  logic        fcb_apbs_penable,
  input  logic        fcb_apbs_pwrite,
  input  logic [31:0] fcb_apbs_pwdata,
  output logic        fcb_apbs_pready,
  output logic [31:0] fcb_apbs_prdata,
  output logic        fcb_apbs_pslverr,
  output logic        fcb_apb_on
);

  fcb_fifo_if #(.WIDTH($bits(wff_entry_t))) wff_if (); // Slave to engine
  fcb_fifo_if #(.WIDTH(32))                 crf_if (); // Engine to slave

  fcb_apb_slave i_apb_slave (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .spi_mode_en   (fcb_spi_mode_en),
    .paddr         (fcb_apbs_paddr),
    .psel          (fcb_apbs_psel),
    .penable       (fcb_apbs_penable),
    .pwrite        (fcb_apbs_pwrite),
    .pwdata        (fcb_apbs_pwdata),
    .pready        (fcb_apbs_pready),
    .prdata        (fcb_apbs_prdata),
    .pslverr       (fcb_apbs_pslverr),
    .apb_on        (fcb_apb_on),
    .wff           (wff_if.producer),
    .crf           (crf_if.consumer)
  );

  fcb_sync_fifo #(.DEPTH(`FCB_WFF_DEPTH), .WIDTH($bits(wff_entry_t))) i_wff (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .f             (wff_if.storage)
  );

  fcb_sync_fifo #(.DEPTH(`FCB_CRF_DEPTH), .WIDTH(32)) i_crf (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .f             (crf_if.storage)
  );

  fcb_cfg_engine i_cfg_engine (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .wff           (wff_if.consumer),
    .crf           (crf_if.producer)
  );

endmodule

// File: fcb_cfg_engine.sv
// Configuration engine behind the FCB APB slave
// Drains the write FIFO into the SFRs and config memory and fills the read FIFO
`include "fcb_consts.svh"

module fcb_cfg_engine
  import fcb_pkg::*;
(
  input logic          fcb_sys_clk,
  input logic          fcb_sys_rst_n,
  fcb_fifo_if.consumer wff, // Entries from the APB slave
  fcb_fifo_if.producer crf  // Read data back to the slave
);

  localparam int AW = $clog2(`FCB_CFG_DEPTH);     // Memory index width
  localparam int CW = $clog2(`FCB_CFG_DEPTH + 1); // Word count width

  logic [31:0]   cfg_mem [`FCB_CFG_DEPTH];
  logic [CW-1:0] wr_ptr_q;       // Stored words and next free slot
  logic [31:0]   ctrl_q;
  logic [31:0]   scratch_q;
  logic [31:0]   rbcnt_q;        // Last clamped read-back count
  logic          busy_q;         // Read-back running
  logic [AW-1:0] rb_idx_q;       // Next word to stream
  logic [CW-1:0] rb_left_q;      // Words still to stream
  logic          crf_wr_en_q;    // Registered push
  logic [31:0]   crf_wr_data_q;

  wff_entry_t    entry;
  wff_kind_e     kind;
  logic          crf_room;  // Slot free after the pending push
  logic          pop;
  logic          rb_push;
  logic          mem_full;
  logic [CW-1:0] rb_cnt;    // RBCNT clamped to stored words
  logic [31:0]   sfr_rdata;

  function automatic wff_kind_e entry_kind(input wff_entry_t e);
    if (!e.wr) begin
      return WFF_SFR_RD;
    end else if (e.addr == `FCB_CFGDP_ADDR) begin
      return WFF_CFG_WR;
    end
    return WFF_SFR_WR;
  endfunction

  assign entry = wff.rd_data;
  assign kind  = entry_kind(entry);

  // Push lands one cycle late so look one slot ahead
  assign crf_room = !crf.full && !(crf.full_m1 && crf_wr_en_q);

  // No pops during read-back, SFR reads need a slot
  assign pop       = !wff.empty && !busy_q && ((kind != WFF_SFR_RD) || crf_room);
  assign wff.rd_en = pop;
  assign rb_push   = busy_q && crf_room;
  assign mem_full  = (wr_ptr_q == CW'(`FCB_CFG_DEPTH));

  assign crf.wr_en   = crf_wr_en_q;
  assign crf.wr_data = crf_wr_data_q;

  assign rb_cnt = (entry.data > 32'(wr_ptr_q)) ? wr_ptr_q : entry.data[CW-1:0];

  // SFR read mux
  always_comb begin
    case (entry.addr)
      `FCB_SFR_CTRL:    sfr_rdata = ctrl_q;
      `FCB_SFR_RBCNT:   sfr_rdata = rbcnt_q;
      `FCB_SFR_STATUS:  sfr_rdata = 32'(wr_ptr_q);
      `FCB_SFR_SCRATCH: sfr_rdata = scratch_q;
      default:          sfr_rdata = '0; // Unimplemented
    endcase
  end

  always_ff @(posedge fcb_sys_clk) begin
    if (pop && (kind == WFF_CFG_WR) && !mem_full) begin
      cfg_mem[wr_ptr_q[AW-1:0]] <= entry.data; // Append
    end
    if (rb_push) begin
      crf_wr_data_q <= cfg_mem[rb_idx_q];
    end else if (pop && (kind == WFF_SFR_RD)) begin
      crf_wr_data_q <= sfr_rdata;
    end
  end

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      wr_ptr_q    <= '0;
      ctrl_q      <= '0;
      scratch_q   <= '0;
      rbcnt_q     <= '0;
      busy_q      <= 1'b0;
      rb_idx_q    <= '0;
      rb_left_q   <= '0;
      crf_wr_en_q <= 1'b0;
    end else begin
      crf_wr_en_q <= rb_push || (pop && (kind == WFF_SFR_RD));

      if (rb_push) begin
        rb_idx_q  <= rb_idx_q + 1'b1;
        rb_left_q <= rb_left_q - 1'b1;
        if (rb_left_q == CW'(1)) begin
          busy_q <= 1'b0; // Last word sent
        end
      end

      if (pop && (kind == WFF_CFG_WR) && !mem_full) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end

      if (pop && (kind == WFF_SFR_WR)) begin
        case (entry.addr)
          `FCB_SFR_CTRL: begin
            ctrl_q <= entry.data;
            if (entry.data[0]) begin
              wr_ptr_q <= '0; // Restart config load
            end
          end
          `FCB_SFR_RBCNT: begin
            rbcnt_q   <= 32'(rb_cnt);
            rb_left_q <= rb_cnt;
            rb_idx_q  <= '0;
            busy_q    <= (rb_cnt != '0); // Zero count starts nothing
          end
          `FCB_SFR_SCRATCH: scratch_q <= entry.data;
          default: ; // Read-only or absent
        endcase
      end
    end
  end

endmodule

// File: fcb_consts.svh
// Shared constants for the FCB configuration path
// Include in any file that needs port addresses, FIFO depths or SFR indices
`ifndef FCB_CONSTS_SVH
`define FCB_CONSTS_SVH

// Word address of the configuration data port in SFR space
`define FCB_CFGDP_ADDR 7'h20

// Write FIFO depth in 40-bit entries
`define FCB_WFF_DEPTH 8

// Configuration read FIFO depth in 32-bit words
`define FCB_CRF_DEPTH 8

// Configuration memory size in words
`define FCB_CFG_DEPTH 32

// SFR word addresses
`define FCB_SFR_CTRL    7'h00 // Bit 0 clears the config write pointer
`define FCB_SFR_RBCNT   7'h01 // Write starts a read-back of N words
`define FCB_SFR_STATUS  7'h02 // Stored config word count
`define FCB_SFR_SCRATCH 7'h03 // Free read/write word

`endif

// File: fcb_fifo_if.sv
// FIFO connection between a producer, a consumer and the storage block
// Instanced once per FIFO at the top level with the data width as parameter
interface fcb_fifo_if #(
  parameter int WIDTH = 32
) ();

  logic             wr_en;    // Push strobe
  logic [WIDTH-1:0] wr_data;
  logic             full;
  logic             full_m1;  // One free slot left
  logic             rd_en;    // Pop strobe
  logic [WIDTH-1:0] rd_data;  // Head word
  logic             empty;
  logic             empty_p1; // Exactly one word held

  // Write side
  modport producer (
    output wr_en, wr_data,
    input  full, full_m1
  );

  // Read side
  modport consumer (
    output rd_en,
    input  rd_data, empty, empty_p1
  );

  // FIFO body
  modport storage (
    input  wr_en, wr_data, rd_en,
    output full, full_m1, rd_data, empty, empty_p1
  );

endinterface

// File: fcb_pkg.sv
// Types shared by the FCB APB slave, the config engine and the testbench
// Import with a wildcard in the module header where needed
package fcb_pkg;

  // APB slave access states
  typedef enum logic [2:0] {
    APS_START    = 3'd0, // One cycle after reset
    APS_IDLE     = 3'd1, // Waiting for PSEL
    APS_WR_DONE  = 3'd2, // PREADY high for a write
    APS_RD_DONE  = 3'd3, // PREADY high for a read
    APS_SFR_WAIT = 3'd4  // SFR read request queued
  } aps_state_e;

  // Kind of a write FIFO entry
  typedef enum logic [1:0] {
    WFF_SFR_RD = 2'd0,
    WFF_SFR_WR = 2'd1,
    WFF_CFG_WR = 2'd2
  } wff_kind_e;

  // Write FIFO entry in bus order
  // Bit 39 is the write flag, bits 38:32 the word address, bits 31:0 the data
  typedef struct packed {
    logic        wr;   // 0 for an SFR read request
    logic [6:0]  addr; // SFR index or config port address
    logic [31:0] data; // Zero on read requests
  } wff_entry_t;

endpackage

// File: fcb_sync_fifo.sv
// Synchronous FIFO with level flags for the FCB write and read paths
// Head word is visible on rd_data and leaves on an rd_en edge
module fcb_sync_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 32
) (
  input logic         fcb_sys_clk,
  input logic         fcb_sys_rst_n,
  fcb_fifo_if.storage f
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer width
  localparam int CW = $clog2(DEPTH + 1);                // Count width

  logic [WIDTH-1:0] mem [DEPTH]; // Circular buffer
  logic [AW-1:0]    wr_ptr_q;
  logic [AW-1:0]    rd_ptr_q;
  logic [CW-1:0]    count_q;   // Words held

  logic do_wr; // Accepted push
  logic do_rd; // Accepted pop

  // Strobes against full or empty are dropped
  assign do_wr = f.wr_en && !f.full;
  assign do_rd = f.rd_en && !f.empty;

  // Flags from the count
  assign f.full     = (count_q == CW'(DEPTH));
  assign f.full_m1  = (count_q == CW'(DEPTH - 1));
  assign f.empty    = (count_q == '0);
  assign f.empty_p1 = (count_q == CW'(1));

  assign f.rd_data = mem[rd_ptr_q]; // Show-ahead head

  always_ff @(posedge fcb_sys_clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= f.wr_data;
    end
  end

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        // Wrap at the last slot
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // None or both
      endcase
    end
  end

endmodule

// File: list.f
+incdir+.
fcb_pkg.sv
fcb_fifo_if.sv
fcb_sync_fifo.sv
fcb_apb_slave.sv
fcb_cfg_engine.sv
fcb_apb_top.sv
tb_fcb_apb.sv

// File: tb_fcb_apb.sv
// Table-driven testbench for the FCB APB configuration path
// Runs SFR, config write, read-back and mode-pin rows through an APB master model
`include "fcb_consts.svh"

module tb_fcb_apb
  import fcb_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {
    OP_WR,  // SFR write
    OP_RD,  // SFR read, compared with exp
    OP_CW,  // data random config writes
    OP_CR,  // data config reads against the model
    OP_RB,  // RBCNT write, starts read-back
    OP_CLR, // CTRL write that clears the pointer
    OP_SPI  // Drive spi mode, exp is apb_on
  } op_e;

  typedef struct packed {
    op_e         kind;
    logic [19:0] addr; // Byte address
    logic [31:0] data;
    logic [31:0] exp;
  } op_t;

  logic        fcb_sys_clk;
  logic        fcb_sys_rst_n;
  logic        fcb_spi_mode_en;
  logic [19:0] fcb_apbs_paddr;
  logic        fcb_apbs_psel;
  logic        fcb_apbs_penable;
  logic        fcb_apbs_pwrite;
  logic [31:0] fcb_apbs_pwdata;
  logic        fcb_apbs_pready;
  logic [31:0] fcb_apbs_prdata;
  logic        fcb_apbs_pslverr;
  logic        fcb_apb_on;

  op_t         rows[$];     // Stimulus table
  logic [31:0] cfg_model[$]; // Stored config words
  integer      seed = 55162;
  int          cycle_cnt = 0;
  int          cycle_limit = 0; // Set once the table is built
  int          rb_pos;          // Next model word expected
  int          rb_len;          // Clamped read-back length

  fcb_apb_top i_dut (.*);

  initial begin
    fcb_sys_clk = 1'b0;
    forever #2 fcb_sys_clk = ~fcb_sys_clk;
  end

  task automatic end_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  // Byte address of a word in SFR space
  function automatic logic [19:0] byte_addr(input logic [6:0] word_addr);
    return {11'd0, word_addr, 2'b00};
  endfunction

  task automatic add_row(input op_e kind, input logic [19:0] addr,
                         input logic [31:0] data, input logic [31:0] exp);
    op_t r;
    r.kind = kind;
    r.addr = addr;
    r.data = data;
    r.exp  = exp;
    rows.push_back(r);
  endtask

  task automatic apb_write(input logic [19:0] addr, input logic [31:0] data);
    @(posedge fcb_sys_clk);
    #1;
    fcb_apbs_psel    = 1'b1; // Setup phase
    fcb_apbs_penable = 1'b0;
    fcb_apbs_pwrite  = 1'b1;
    fcb_apbs_paddr   = addr;
    fcb_apbs_pwdata  = data;
    @(posedge fcb_sys_clk);
    #1;
    fcb_apbs_penable = 1'b1; // Access phase
    while (fcb_apbs_pready !== 1'b1) begin
      @(posedge fcb_sys_clk);
      #1;
    end
    @(posedge fcb_sys_clk); // Transfer ends here
    #1;
    fcb_apbs_psel    = 1'b0;
    fcb_apbs_penable = 1'b0;
  endtask

  task automatic apb_read(input logic [19:0] addr, output logic [31:0] data);
    @(posedge fcb_sys_clk);
    #1;
    fcb_apbs_psel    = 1'b1;
    fcb_apbs_penable = 1'b0;
    fcb_apbs_pwrite  = 1'b0;
    fcb_apbs_paddr   = addr;
    @(posedge fcb_sys_clk);
    #1;
    fcb_apbs_penable = 1'b1;
    while (fcb_apbs_pready !== 1'b1) begin
      @(posedge fcb_sys_clk);
      #1;
    end
    data = fcb_apbs_prdata; // Stable until the closing edge
    @(posedge fcb_sys_clk);
    #1;
    fcb_apbs_psel    = 1'b0;
    fcb_apbs_penable = 1'b0;
  endtask

  // Cycle watchdog and pslverr monitor sampled mid-cycle
  always @(negedge fcb_sys_clk) begin
    cycle_cnt++;
    check_flag(fcb_apbs_pslverr, 1'b0, "pslverr");
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      end_with_failure();
    end
  end

  task automatic build_table();
    add_row(OP_SPI, 20'h0, 32'd0, 32'd1);
    add_row(OP_WR,  byte_addr(`FCB_SFR_SCRATCH), 32'h1234_5678, 32'h0);
    add_row(OP_RD,  byte_addr(`FCB_SFR_SCRATCH), 32'h0, 32'h1234_5678);
    add_row(OP_WR,  byte_addr(`FCB_SFR_CTRL), 32'hA5A5_0000, 32'h0);   // Bit 0 clear
    add_row(OP_RD,  byte_addr(`FCB_SFR_CTRL), 32'h0, 32'hA5A5_0000);
    add_row(OP_RD,  20'h0_0010, 32'h0, 32'h0);                          // Unimplemented SFR
    add_row(OP_RD,  20'h0_01FC, 32'h0, 32'h0);                          // Top of SFR space
    add_row(OP_CW,  byte_addr(`FCB_CFGDP_ADDR), 32'd2, 32'h0);
    add_row(OP_CW,  20'h4_0000, 32'd2, 32'h0);                          // High alias
    add_row(OP_CW,  20'hF_FFFC, 32'd1, 32'h0);
    add_row(OP_RD,  byte_addr(`FCB_SFR_STATUS), 32'h0, 32'd5);
    add_row(OP_RB,  byte_addr(`FCB_SFR_RBCNT), 32'd5, 32'h0);
    add_row(OP_CR,  byte_addr(`FCB_CFGDP_ADDR), 32'd3, 32'h0);
    add_row(OP_CR,  20'h2_0000, 32'd2, 32'h0);
    add_row(OP_RD,  byte_addr(`FCB_SFR_RBCNT), 32'h0, 32'd5);
    add_row(OP_CLR, byte_addr(`FCB_SFR_CTRL), 32'h1, 32'h0);
    add_row(OP_RD,  byte_addr(`FCB_SFR_STATUS), 32'h0, 32'd0);
    add_row(OP_CW,  byte_addr(`FCB_CFGDP_ADDR), 32'd3, 32'h0);
    add_row(OP_RD,  byte_addr(`FCB_SFR_STATUS), 32'h0, 32'd3);
    add_row(OP_RB,  byte_addr(`FCB_SFR_RBCNT), 32'd40, 32'h0);          // Clamps to 3
    add_row(OP_CR,  byte_addr(`FCB_CFGDP_ADDR), 32'd3, 32'h0);
    add_row(OP_RD,  byte_addr(`FCB_SFR_RBCNT), 32'h0, 32'd3);
    add_row(OP_RD,  byte_addr(`FCB_SFR_CTRL), 32'h0, 32'h1);
    add_row(OP_CLR, byte_addr(`FCB_SFR_CTRL), 32'h1, 32'h0);
    add_row(OP_CW,  byte_addr(`FCB_CFGDP_ADDR), 32'd6, 32'h0);          // Burst past wff depth
    add_row(OP_CW,  20'h8_0000, 32'd6, 32'h0);
    add_row(OP_RD,  byte_addr(`FCB_SFR_STATUS), 32'h0, 32'd12);
    add_row(OP_RB,  byte_addr(`FCB_SFR_RBCNT), 32'd12, 32'h0);          // More than crf holds
    add_row(OP_CR,  byte_addr(`FCB_CFGDP_ADDR), 32'd12, 32'h0);
    add_row(OP_SPI, 20'h0, 32'd1, 32'd0);
    add_row(OP_WR,  byte_addr(`FCB_SFR_SCRATCH), 32'hDEAD_BEEF, 32'h0);
    add_row(OP_RD,  byte_addr(`FCB_SFR_SCRATCH), 32'h0, 32'hDEAD_BEEF);
    add_row(OP_SPI, 20'h0, 32'd0, 32'd1);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] word;
    fcb_sys_rst_n    = 1'b0;
    fcb_spi_mode_en  = 1'b0;
    fcb_apbs_paddr   = '0;
    fcb_apbs_psel    = 1'b0;
    fcb_apbs_penable = 1'b0;
    fcb_apbs_pwrite  = 1'b0;
    fcb_apbs_pwdata  = '0;
    rb_pos = 0;
    rb_len = 0;
    build_table();
    cycle_limit = rows.size() * 40;
    repeat (3) @(posedge fcb_sys_clk);
    #1;
    fcb_sys_rst_n = 1'b1;

    foreach (rows[i]) begin
      case (rows[i].kind)
        OP_SPI: begin
          @(posedge fcb_sys_clk);
          #1;
          fcb_spi_mode_en = rows[i].data[0];
          @(posedge fcb_sys_clk);
          #1;
          check_flag(fcb_apb_on, rows[i].exp[0], "apb_on");
        end
        OP_WR: apb_write(rows[i].addr, rows[i].data);
        OP_RD: begin
          apb_read(rows[i].addr, rd);
          check_rdata(rd, rows[i].exp, "SFR");
        end
        OP_CW: begin
          repeat (rows[i].data) begin
            word = $random(seed);
            apb_write(rows[i].addr, word);
            if (cfg_model.size() < `FCB_CFG_DEPTH) begin
              cfg_model.push_back(word); // Writes past the end are dropped
            end
          end
        end
        OP_CR: begin
          repeat (rows[i].data) begin
            if (rb_pos >= rb_len) begin
              $display("Table row %0d reads more words than the read-back holds", i);
              end_with_failure();
            end
            apb_read(rows[i].addr, rd);
            check_rdata(rd, cfg_model[rb_pos], "config read-back");
            rb_pos++;
          end
        end
        OP_RB: begin
          apb_write(rows[i].addr, rows[i].data);
          rb_pos = 0;
          rb_len = (rows[i].data > cfg_model.size()) ? cfg_model.size() : rows[i].data;
        end
        OP_CLR: begin
          apb_write(rows[i].addr, rows[i].data);
          cfg_model.delete(); // Pointer back to zero
        end
        default: begin
          $display("Table row %0d has an unknown operation", i);
          end_with_failure();
        end
      endcase
    end

    repeat (4) @(posedge fcb_sys_clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule
